// File: source/fetch_pkg.sv
package fetch_pkg;

    // Address geometry
    localparam int ADDR_WIDTH = 32;
    localparam logic [ADDR_WIDTH-1:0] RESET_PC = ADDR_WIDTH'(32'h0000_0100);
    localparam logic [ADDR_WIDTH-1:0] INSTR_BYTES = ADDR_WIDTH'(4);  // Sequential fetch step

    // Branch target buffer
    localparam int BTB_SIZE = 16;                  // Total entries
    localparam int NUM_WAYS = 4;
    localparam int NUM_SETS = BTB_SIZE / NUM_WAYS;
    localparam int SET_BITS = $clog2(NUM_SETS);    // Set index is the low PC bits
    localparam int WAY_BITS = $clog2(NUM_WAYS);

    // Fetch queue, depth must be a power of two
    localparam int FQ_DEPTH = 4;
    localparam int FQ_PTR_W = $clog2(FQ_DEPTH);

endpackage

// File: source/btb_4way.sv
`timescale 1ns/1ps

module btb_4way (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0] predict_pc,
    input  logic                             update_valid,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0] update_pc,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0] update_target,
    output logic [fetch_pkg::ADDR_WIDTH-1:0] predicted_pc,
    output logic                             prediction
);
    import fetch_pkg::*;

    // Table storage
    logic [ADDR_WIDTH-1:0] tag_q    [NUM_SETS][NUM_WAYS];
    logic [ADDR_WIDTH-1:0] target_q [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0]   valid_q  [NUM_SETS];

    logic [SET_BITS-1:0] lookup_set;
    logic [SET_BITS-1:0] upd_set;
    logic [NUM_WAYS-1:0] upd_hit;      // Every matching way, one at most
    logic [NUM_WAYS-1:0] upd_empty;    // Lowest free way, one-hot

    // First update stage
    logic                  upd_valid_q;
    logic [NUM_WAYS-1:0]   hit_q;
    logic [NUM_WAYS-1:0]   empty_q;
    logic [ADDR_WIDTH-1:0] upd_pc_q;
    logic [ADDR_WIDTH-1:0] upd_target_q;

    logic [SET_BITS-1:0] wr_set;
    logic [WAY_BITS-1:0] wr_way;

    assign lookup_set = predict_pc[SET_BITS-1:0];
    assign upd_set    = update_pc[SET_BITS-1:0];
    assign wr_set     = upd_pc_q[SET_BITS-1:0];

    // Lookup, the lowest hitting way wins
    always_comb begin
        prediction   = 1'b0;
        predicted_pc = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (valid_q[lookup_set][w] && tag_q[lookup_set][w] == predict_pc) begin
                prediction   = 1'b1;
                predicted_pc = target_q[lookup_set][w];
            end
        end
    end

    // Hit and empty search for the incoming update
    always_comb begin
        upd_hit   = '0;
        upd_empty = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            upd_hit[w] = valid_q[upd_set][w] && tag_q[upd_set][w] == update_pc;
            if (!valid_q[upd_set][w]) begin
                upd_empty = NUM_WAYS'(1) << w;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            upd_valid_q <= 1'b0;
            hit_q       <= '0;
            empty_q     <= '0;
        end else begin
            upd_valid_q <= update_valid;
            if (update_valid) begin
                hit_q   <= upd_hit;
                empty_q <= upd_empty;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (update_valid) begin
            upd_pc_q     <= update_pc;
            upd_target_q <= update_target;
        end
    end

    // Hit way first, then lowest empty way, else way 0
    always_comb begin
        wr_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (hit_q[w] || (hit_q == '0 && empty_q[w])) begin
                wr_way = WAY_BITS'(w);
            end
        end
    end

    // Second update stage
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (upd_valid_q) begin
            valid_q[wr_set][wr_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upd_valid_q) begin
            tag_q[wr_set][wr_way]    <= upd_pc_q;
            target_q[wr_set][wr_way] <= upd_target_q;
        end
    end

    // A tag lives in one way of its set only, and one free way is picked
    a_hit_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(hit_q));
    a_empty_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(empty_q));

endmodule

// File: source/pc_gen.sv
`timescale 1ns/1ps

module pc_gen (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             redirect_valid,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0] redirect_pc,
    input  logic                             prediction,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0] predicted_pc,
    input  logic                             push_ready,
    output logic [fetch_pkg::ADDR_WIDTH-1:0] fetch_pc,
    output logic                             push_valid,
    output logic [fetch_pkg::ADDR_WIDTH-1:0] push_pc,
    output logic                             push_taken,
    output logic [fetch_pkg::ADDR_WIDTH-1:0] push_target
);
    import fetch_pkg::*;

    logic fire;

    // Nothing is offered in reset or in a redirect cycle, whose PC is stale
    assign push_valid  = !rst && !redirect_valid;
    assign push_pc     = fetch_pc;
    assign push_taken  = prediction;
    assign push_target = predicted_pc;
    assign fire        = push_valid && push_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fetch_pc <= RESET_PC;
        end else begin
            if (redirect_valid) begin
                fetch_pc <= redirect_pc;   // Wins over a full queue
            end else if (fire) begin
                fetch_pc <= prediction ? predicted_pc : fetch_pc + INSTR_BYTES;
            end
        end
    end

    // Offered PC holds while the queue is full
    a_push_stable: assert property (@(posedge clk) disable iff (rst)
        push_valid && !push_ready && !redirect_valid |=> $stable(push_pc));

endmodule

// File: source/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             flush,
    input  logic                             push_valid,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0] push_pc,
    input  logic                             push_taken,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0] push_target,
    input  logic                             pop,
    output logic                             push_ready,
    output logic                             head_valid,
    output logic [fetch_pkg::ADDR_WIDTH-1:0] head_pc,
    output logic                             head_taken,
    output logic [fetch_pkg::ADDR_WIDTH-1:0] head_target
);
    import fetch_pkg::*;

    logic [ADDR_WIDTH-1:0] pc_mem     [FQ_DEPTH];
    logic                  taken_mem  [FQ_DEPTH];
    logic [ADDR_WIDTH-1:0] target_mem [FQ_DEPTH];

    logic [FQ_PTR_W-1:0] wr_ptr;
    logic [FQ_PTR_W-1:0] rd_ptr;
    logic [FQ_PTR_W:0]   count;   // One extra bit to hold FQ_DEPTH
    logic                do_push;
    logic                do_pop;

    assign push_ready  = count != (FQ_PTR_W + 1)'(FQ_DEPTH);
    assign head_valid  = count != '0;
    assign head_pc     = pc_mem[rd_ptr];
    assign head_taken  = taken_mem[rd_ptr];
    assign head_target = target_mem[rd_ptr];

    // Flush drops any push in the same cycle
    assign do_push = push_valid && push_ready && !flush;
    assign do_pop  = pop && head_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;   // Wraps at FQ_DEPTH
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            pc_mem[wr_ptr]     <= push_pc;
            taken_mem[wr_ptr]  <= push_taken;
            target_mem[wr_ptr] <= push_target;
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        pop |-> head_valid);
    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= (FQ_PTR_W + 1)'(FQ_DEPTH));

endmodule

// File: source/branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve (
    input  logic                             resolve_valid,
    input  logic                             resolve_taken,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0] resolve_target,
    input  logic                             head_valid,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0] head_pc,
    input  logic                             head_taken,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0] head_target,
    output logic                             pop,
    output logic                             update_valid,
    output logic [fetch_pkg::ADDR_WIDTH-1:0] update_pc,
    output logic [fetch_pkg::ADDR_WIDTH-1:0] update_target,
    output logic                             redirect_valid,
    output logic [fetch_pkg::ADDR_WIDTH-1:0] redirect_pc,
    output logic                             mispredict
);
    import fetch_pkg::*;

    logic                  accept;
    logic [ADDR_WIDTH-1:0] actual_next;
    logic                  dir_wrong;
    logic                  target_wrong;

    assign accept = resolve_valid && head_valid;

    // Where fetch should really have gone after this head
    assign actual_next = resolve_taken ? resolve_target : head_pc + INSTR_BYTES;

    assign dir_wrong    = resolve_taken != head_taken;
    assign target_wrong = resolve_taken && head_taken && (resolve_target != head_target);
    assign mispredict   = accept && (dir_wrong || target_wrong);

    assign pop = accept;

    // Taken branches train the BTB, not-taken ones leave it alone
    assign update_valid  = accept && resolve_taken;
    assign update_pc     = head_pc;
    assign update_target = resolve_target;

    assign redirect_valid = mispredict;
    assign redirect_pc    = actual_next;

endmodule

// File: source/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             resolve_valid,
    input  logic                             resolve_taken,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0] resolve_target,
    output logic                             resolve_ready,
    output logic [fetch_pkg::ADDR_WIDTH-1:0] head_pc,
    output logic                             head_taken,
    output logic [fetch_pkg::ADDR_WIDTH-1:0] head_target,
    output logic                             mispredict
);
    import fetch_pkg::*;

    // Lookup path
    logic [ADDR_WIDTH-1:0] fetch_pc;
    logic [ADDR_WIDTH-1:0] predicted_pc;
    logic                  prediction;

    // Fetch push
    logic                  push_valid;
    logic                  push_ready;
    logic [ADDR_WIDTH-1:0] push_pc;
    logic                  push_taken;
    logic [ADDR_WIDTH-1:0] push_target;

    logic                  head_valid;
    logic                  pop;

    // Update and redirect
    logic                  update_valid;
    logic [ADDR_WIDTH-1:0] update_pc;
    logic [ADDR_WIDTH-1:0] update_target;
    logic                  redirect_valid;
    logic [ADDR_WIDTH-1:0] redirect_pc;

    assign resolve_ready = head_valid;   // Execute may only resolve a queued fetch

    btb_4way u_btb (
        .clk           (clk),
        .rst           (rst),
        .predict_pc    (fetch_pc),
        .update_valid  (update_valid),
        .update_pc     (update_pc),
        .update_target (update_target),
        .predicted_pc  (predicted_pc),
        .prediction    (prediction)
    );

    pc_gen u_pc_gen (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .prediction     (prediction),
        .predicted_pc   (predicted_pc),
        .push_ready     (push_ready),
        .fetch_pc       (fetch_pc),
        .push_valid     (push_valid),
        .push_pc        (push_pc),
        .push_taken     (push_taken),
        .push_target    (push_target)
    );

    fetch_queue u_fq (
        .clk         (clk),
        .rst         (rst),
        .flush       (redirect_valid),
        .push_valid  (push_valid),
        .push_pc     (push_pc),
        .push_taken  (push_taken),
        .push_target (push_target),
        .pop         (pop),
        .push_ready  (push_ready),
        .head_valid  (head_valid),
        .head_pc     (head_pc),
        .head_taken  (head_taken),
        .head_target (head_target)
    );

    branch_resolve u_resolve (
        .resolve_valid  (resolve_valid),
        .resolve_taken  (resolve_taken),
        .resolve_target (resolve_target),
        .head_valid     (head_valid),
        .head_pc        (head_pc),
        .head_taken     (head_taken),
        .head_target    (head_target),
        .pop            (pop),
        .update_valid   (update_valid),
        .update_pc      (update_pc),
        .update_target  (update_target),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .mispredict     (mispredict)
    );

    // A resolve is only meaningful against a valid queue head
    a_resolve_has_head: assert property (@(posedge clk) disable iff (rst)
        resolve_valid |-> head_valid);

endmodule

// File: dv/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;
    import fetch_pkg::*;

    localparam int CYCLE_LIMIT = 2000;   // Tests need a few hundred cycles

    logic                  clk;
    logic                  rst;
    logic                  resolve_valid;
    logic                  resolve_taken;
    logic [ADDR_WIDTH-1:0] resolve_target;
    logic                  resolve_ready;
    logic [ADDR_WIDTH-1:0] head_pc;
    logic                  head_taken;
    logic [ADDR_WIDTH-1:0] head_target;
    logic                  mispredict;

    // Reference BTB contents
    logic [ADDR_WIDTH-1:0] m_tag    [NUM_SETS][NUM_WAYS];
    logic [ADDR_WIDTH-1:0] m_target [NUM_SETS][NUM_WAYS];
    logic                  m_valid  [NUM_SETS][NUM_WAYS];

    // What the current head should look like
    logic [ADDR_WIDTH-1:0] exp_pc;
    logic [ADDR_WIDTH-1:0] exp_target;
    logic                  exp_taken;
    logic                  exp_mis;

    int          err_count     = 0;
    int          resolve_count = 0;
    int          cycle_count   = 0;
    int unsigned seed_val;
    logic        rand_taken;

    fetch_top uut (
        .clk            (clk),
        .rst            (rst),
        .resolve_valid  (resolve_valid),
        .resolve_taken  (resolve_taken),
        .resolve_target (resolve_target),
        .resolve_ready  (resolve_ready),
        .head_pc        (head_pc),
        .head_taken     (head_taken),
        .head_target    (head_target),
        .mispredict     (mispredict)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: tests still running after %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic report_mismatch(input string sig, input logic [ADDR_WIDTH-1:0] expected,
                                   input logic [ADDR_WIDTH-1:0] actual);
        err_count++;
        $display("mismatch at %0t: %s expected %h actual %h", $time, sig, expected, actual);
    endtask

    task automatic clear_model();
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                m_valid[s][w]  = 1'b0;
                m_tag[s][w]    = '0;
                m_target[s][w] = '0;
            end
        end
    endtask

    // Prediction for exp_pc, first matching way
    task automatic refresh_expect();
        int set_idx;
        set_idx    = int'(exp_pc[SET_BITS-1:0]);
        exp_taken  = 1'b0;
        exp_target = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!exp_taken && m_valid[set_idx][w] && m_tag[set_idx][w] == exp_pc) begin
                exp_taken  = 1'b1;
                exp_target = m_target[set_idx][w];
            end
        end
    endtask

    // Hit way is rewritten, else first free way, else way 0
    task automatic model_update(input logic [ADDR_WIDTH-1:0] pc,
                                input logic [ADDR_WIDTH-1:0] target);
        int set_idx;
        int way;
        set_idx = int'(pc[SET_BITS-1:0]);
        way     = -1;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way < 0 && m_valid[set_idx][w] && m_tag[set_idx][w] == pc) begin
                way = w;
            end
        end
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way < 0 && !m_valid[set_idx][w]) begin
                way = w;
            end
        end
        if (way < 0) begin
            way = 0;
        end
        m_valid[set_idx][way]  = 1'b1;
        m_tag[set_idx][way]    = pc;
        m_target[set_idx][way] = target;
    endtask

    // Resolve the current head, called and returning on a falling edge
    task automatic resolve_one(input logic taken, input logic [ADDR_WIDTH-1:0] target);
        int                    gap;
        logic [ADDR_WIDTH-1:0] next_pc;
        gap = int'($urandom % 3);
        repeat (gap) @(negedge clk);
        while (!resolve_ready) begin
            @(negedge clk);
        end
        resolve_valid  = 1'b1;
        resolve_taken  = taken;
        resolve_target = target;
        exp_mis = (taken != exp_taken) || (taken && exp_taken && target != exp_target);
        next_pc = taken ? target : exp_pc + INSTR_BYTES;
        @(negedge clk);
        resolve_valid  = 1'b0;
        resolve_taken  = 1'b0;
        resolve_target = '0;
        exp_mis        = 1'b0;
        if (taken) begin
            model_update(exp_pc, target);
        end
        exp_pc = next_pc;   // Redirect or not, fetch continues here
        refresh_expect();
        resolve_count++;
    endtask

    task automatic resolve_seq(input int count);
        for (int i = 0; i < count; i++) begin
            resolve_one(1'b0, '0);
        end
    endtask

    task automatic apply_reset();
        rst            = 1'b1;
        resolve_valid  = 1'b0;
        resolve_taken  = 1'b0;
        resolve_target = '0;
        exp_mis        = 1'b0;
        clear_model();
        exp_pc = RESET_PC;
        refresh_expect();
        repeat (16) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s finished, %0d errors so far", num, name, err_count);
    endtask

    a_head_pc: assert property (@(posedge clk) disable iff (rst)
        resolve_ready |-> head_pc == exp_pc)
        else report_mismatch("head_pc", exp_pc, $sampled(head_pc));
    a_head_taken: assert property (@(posedge clk) disable iff (rst)
        resolve_ready |-> head_taken == exp_taken)
        else report_mismatch("head_taken", ADDR_WIDTH'(exp_taken),
                             ADDR_WIDTH'($sampled(head_taken)));
    a_head_target: assert property (@(posedge clk) disable iff (rst)
        resolve_ready && exp_taken |-> head_target == exp_target)
        else report_mismatch("head_target", exp_target, $sampled(head_target));
    a_mispredict: assert property (@(posedge clk) disable iff (rst)
        resolve_ready |-> mispredict == exp_mis)
        else report_mismatch("mispredict", ADDR_WIDTH'(exp_mis),
                             ADDR_WIDTH'($sampled(mispredict)));

    // First head one edge after reset, redirected head two edges after a flush
    a_first_head: assert property (@(posedge clk) disable iff (rst)
        $fell(rst) |=> resolve_ready)
        else report_mismatch("resolve_ready", ADDR_WIDTH'(1),
                             ADDR_WIDTH'($sampled(resolve_ready)));
    a_flush_empty: assert property (@(posedge clk) disable iff (rst)
        mispredict |=> !resolve_ready)
        else report_mismatch("resolve_ready", ADDR_WIDTH'(0),
                             ADDR_WIDTH'($sampled(resolve_ready)));
    a_redirect_head: assert property (@(posedge clk) disable iff (rst)
        $past(mispredict, 2) |-> resolve_ready)
        else report_mismatch("resolve_ready", ADDR_WIDTH'(1),
                             ADDR_WIDTH'($sampled(resolve_ready)));

    initial begin
        seed_val = $urandom(10);
        apply_reset();

        resolve_seq(6);   // Heads 0x100 to 0x114
        report_test(1, "sequential fetch");

        resolve_one(1'b1, 32'h400);   // Branch at 0x118 learned
        resolve_one(1'b1, 32'h110);   // Loop back from 0x400
        resolve_seq(2);
        resolve_one(1'b1, 32'h400);   // 0x118 now predicted
        report_test(2, "taken branch learning");

        resolve_one(1'b1, 32'h110);
        resolve_seq(2);
        resolve_one(1'b1, 32'h500);   // New target for 0x118
        resolve_one(1'b1, 32'h110);
        resolve_seq(2);
        resolve_one(1'b1, 32'h500);
        report_test(3, "target change");

        apply_reset();
        resolve_one(1'b1, 32'h104);   // Ways 0 to 3 of set 0
        resolve_one(1'b1, 32'h108);
        resolve_one(1'b1, 32'h10c);
        resolve_one(1'b1, 32'h110);
        resolve_one(1'b1, 32'h301);   // Fifth branch evicts way 0
        resolve_one(1'b1, 32'h100);   // Return through set 1
        resolve_one(1'b0, '0);        // 0x100 no longer predicted
        resolve_one(1'b1, 32'h108);
        resolve_one(1'b1, 32'h10c);
        resolve_one(1'b1, 32'h110);
        resolve_one(1'b1, 32'h301);
        report_test(4, "replacement");

        repeat (12) @(negedge clk);   // Queue fills behind a held head
        resolve_one(1'b0, '0);        // Predicted taken, really falls through
        for (int i = 0; i < 8; i++) begin
            rand_taken = 1'($urandom % 2);
            resolve_one(rand_taken, exp_pc + 32'h8);
        end
        report_test(5, "back-pressure and flush");

        $display("5 tests, %0d resolves, %0d errors", resolve_count, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: project.f
source/fetch_pkg.sv
source/btb_4way.sv
source/pc_gen.sv
source/fetch_queue.sv
source/branch_resolve.sv
source/fetch_top.sv
dv/fetch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch front end testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f project.f --top-module fetch_tb -o fetch_sim

./obj_dir/fetch_sim > sim.log 2>&1
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
